/* project.f */
+incdir+verif
hw/ringPkg.sv
hw/dmaPkg.sv
hw/stageFifo.sv
hw/txFetch.sv
hw/rxDrain.sv
hw/burstSequencer.sv
hw/ringPort.sv
hw/ethDmaTop.sv
verif/ethDmaTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ethDmaTop testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module ethDmaTb -o simv
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
exit 1

/* verif/ringMemModel.svh */
// memory word for one line and word slot, covers the whole line address
function automatic logic [31:0] lineWord(input lineAddr line, input int idx);
  return {line, 4'(idx)};
endfunction

task automatic reportValue(input string name, input logic [63:0] expected, input logic [63:0] actual);
  $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
  errors++;
endtask

task automatic failNote(input string what);
  $display("Failure at %0t ns: %s", $time, what);
  errors++;
endtask

// idle ring traffic, token every 12 to 40 cycles
task automatic driveRing();
  coreId other;
  int pick;
  other = me ^ 4'(1 + $urandom % 15);           // never our own number
  pick  = $urandom % 16;
  if (tokenTimer == 0) begin
    ringIn     = '{payload: 32'($urandom), kind: slotToken, source: other};
    tokenTimer = 12 + $urandom % 29;
  end else begin
    tokenTimer--;
    if (allowOwn && pick == 0) ringIn = '{payload: 32'($urandom), kind: slotAddress, source: me};
    else if (pick < 3) ringIn = '{payload: 32'($urandom), kind: slotWriteData, source: other};
    else ringIn = '{payload: 32'($urandom), kind: slotNull, source: other};
  end
endtask

// eight words per read, in request order
task automatic driveReturn();
  if (retLeft > 0) begin
    readReturn = lineWord(retLine, 8 - retLeft);
    readDest   = me;
    retLeft--;
  end else if (pendLine.size() > 0 && pendCycle[0] <= cycle) begin
    retLine    = pendLine.pop_front();
    void'(pendCycle.pop_front());
    readReturn = lineWord(retLine, 0);
    readDest   = me;
    retLeft    = 7;
  end else begin
    readReturn = $urandom;
    readDest   = me + 4'd1;                      // traffic for another core
  end
endtask

// one slot that the core drove itself
task automatic handleBurstSlot();
  if (ringOut.kind == slotWriteData) begin
    groupWords++;
    if (expWr.size() == 0) failNote("write data slot with no frame data pending");
    else if (ringOut.payload !== expWr[0]) reportValue("write data", expWr[0], ringOut.payload);
    if (expWr.size() > 0) void'(expWr.pop_front());
  end else if (ringOut.payload[31:28] == readTag) begin
    if (stopWatch) failNote("read address slot while txStop is high");
    if (expRead.size() == 0) begin
      failNote("read address slot with no block pending");
    end else begin
      if (ringOut.payload !== {readTag, expRead[0]})
        reportValue("read address", {readTag, expRead[0]}, ringOut.payload);
      void'(expRead.pop_front());
    end
    pendLine.push_back(ringOut.payload[27:0]);
    pendCycle.push_back(cycle + 2 + $urandom % 12);  // memory latency
  end else begin
    if (groupWords != 8) failNote($sformatf("write burst of %0d data slots", groupWords));
    groupWords = 0;
    if (expWrAddr.size() == 0) begin
      failNote("write address slot with no line pending");
    end else begin
      if (ringOut.payload !== {writeTag, expWrAddr[0]})
        reportValue("write address", {writeTag, expWrAddr[0]}, ringOut.payload);
      void'(expWrAddr.pop_front());
    end
  end
endtask

/* verif/ethDmaTb.sv */
`timescale 1ns/1ps

module ethDmaTb
  import ringPkg::*;
  import dmaPkg::*;
();

  localparam coreId me = 4'd5;
  localparam int budgetCycles = 60 + 12000 + 5000 + 4000 + 12000 + 15400 + 100;
  localparam ringSlot nullSlot = '{payload: 32'd0, kind: slotNull, source: me};

  logic clock, reset, txDescEmpty, txDescRead, txWrite, txStop;
  logic rxReady, rxRead, rxAddrEmpty, rxAddrRead, frameLengthWrite;
  ringSlot ringIn, ringOut;
  logic [31:0] readReturn, txWord;
  coreId readDest;
  txDescriptor txDesc;
  lineAddr txAddr, rxAddr, retLine;
  rxWord rxHead;
  logic [12:0] frameLength;

  txDescriptor txDescQ[$];                       // transmit descriptor queue
  lineAddr txAddrQ[$], rxAddrQ[$], expRead[$], expWrAddr[$], pendLine[$];
  rxWord rxWordQ[$];                             // receive word queue
  logic [31:0] expTx[$], expWr[$];
  logic [12:0] expLen[$];
  int pendCycle[$];
  int errors = 0, cycle = 0, tokenTimer = 15, retLeft = 0, groupWords = 0, releases = 0;
  int e0, rel0;
  bit burstOpen = 0, allowOwn = 0, quietWatch = 0, stopWatch = 0;
  bit txPop = 0, rxPop = 0, rxAddrPop = 0;

  `include "ringMemModel.svh"

  ethDmaTop UUT (
    .clock (clock), .reset (reset), .coreNumber (me), .ringIn (ringIn), .ringOut (ringOut),
    .readReturn (readReturn), .readDest (readDest), .txDesc (txDesc), .txAddr (txAddr),
    .txDescEmpty (txDescEmpty), .txDescRead (txDescRead), .txWord (txWord),
    .txWrite (txWrite), .txStop (txStop), .rxWord (rxHead), .rxReady (rxReady),
    .rxRead (rxRead), .rxAddr (rxAddr), .rxAddrEmpty (rxAddrEmpty), .rxAddrRead (rxAddrRead),
    .frameLength (frameLength), .frameLengthWrite (frameLengthWrite)
  );

  always #4 clock = ~clock;

  function automatic bit allDone();
    return txDescQ.size() == 0 && expTx.size() == 0 && expRead.size() == 0 && retLeft == 0 &&
           pendLine.size() == 0 && rxWordQ.size() == 0 && expWr.size() == 0 &&
           expWrAddr.size() == 0 && expLen.size() == 0;
  endfunction

  task automatic addDescriptor(input int len);
    txDescriptor d;
    d = txDescriptor'($urandom);
    d.payloadLength = 11'(len);
    txDescQ.push_back(d);
    txAddrQ.push_back(lineAddr'($urandom));
  endtask

  // expected ring and memory traffic built with the frame
  task automatic addFrame(input int n, input lineAddr line);
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      w = $urandom;
      rxWordQ.push_back({1'b0, w});
      if (line != 0) expWr.push_back(w);
    end
    if (line != 0) begin
      for (int i = n; i < ((n + 7) / 8) * 8; i++) expWr.push_back(w);  // pad with last word
      for (int g = 0; g < (n + 7) / 8; g++) expWrAddr.push_back(line + lineAddr'(g));
    end
    w = $urandom;
    rxWordQ.push_back({1'b1, w});                // length report word
    if (line != 0) expLen.push_back(w[12:0]);
    rxAddrQ.push_back(line);
  endtask

  task automatic waitIdle(input int limit);
    int n;
    n = 0;
    while (!allDone() && n < limit) begin
      @(posedge clock);
      n++;
    end
    if (!allDone()) failNote($sformatf("traffic not finished after %0d cycles", limit));
  endtask

  task automatic reportTest(input string name);
    $display("test %s: %s (%0d errors)", name, (errors == e0) ? "passed" : "failed", errors - e0);
  endtask

  // inputs change 1 ns after the edge
  always @(posedge clock) begin
    #1;
    cycle++;
    if (txPop) begin
      void'(txDescQ.pop_front());
      void'(txAddrQ.pop_front());
    end
    if (rxPop) void'(rxWordQ.pop_front());
    if (rxAddrPop) void'(rxAddrQ.pop_front());
    txPop = 0;
    rxPop = 0;
    rxAddrPop = 0;
    driveRing();
    driveReturn();
    txDescEmpty = txDescQ.size() == 0 || retLeft > 0 || pendLine.size() > 0;  // one frame at a time
    if (txDescQ.size() > 0) txDesc = txDescQ[0];
    if (txAddrQ.size() > 0) txAddr = txAddrQ[0];
    rxReady = rxWordQ.size() > 0;
    if (rxReady) rxHead = rxWordQ[0];
    rxAddrEmpty = rxAddrQ.size() == 0;
    if (!rxAddrEmpty) rxAddr = rxAddrQ[0];
  end

  // outputs are settled at the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      if (txDescRead) begin
        txPop = 1;
        expTx.push_back({5'b0, txDesc});          // descriptor leads the stream
        for (int b = 0; b < (txDesc.payloadLength + 31) / 32; b++)
          expRead.push_back(txAddr + lineAddr'(b));
        for (int k = 0; k < (txDesc.payloadLength + 3) / 4; k++)
          expTx.push_back(lineWord(txAddr + lineAddr'(k / 8), k % 8));
      end
      if (txWrite) begin
        if (expTx.size() == 0) failNote("txWrite with no word expected");
        else if (txWord !== expTx[0]) reportValue("txWord", expTx[0], txWord);
        if (expTx.size() > 0) void'(expTx.pop_front());
      end
      if (rxRead) rxPop = 1;
      if (rxAddrRead) rxAddrPop = 1;
      if (frameLengthWrite) begin
        if (expLen.size() == 0) failNote("frameLengthWrite with no frame expected");
        else if (frameLength !== expLen[0]) reportValue("frameLength", expLen[0], frameLength);
        if (expLen.size() > 0) void'(expLen.pop_front());
      end
      if (quietWatch && (txDescRead | txWrite | rxRead | rxAddrRead | frameLengthWrite))
        failNote("queue or stream activity with no work queued");
      if (ringIn.kind == slotToken && ringIn.source != me && burstOpen)
        failNote("injected token came before the core released its own");
      if (ringOut.source == me && ringOut.kind == slotToken) begin
        releases++;
        if (!burstOpen) failNote("token released with no burst sent");
        burstOpen = 0;
      end else if (ringOut.source == me && ringOut.kind inside {slotAddress, slotWriteData}) begin
        burstOpen = 1;
        handleBurstSlot();
      end else if (ringIn.source == me && !(ringIn.kind inside {slotNull, slotToken})) begin
        if (ringOut !== nullSlot)
          reportValue("ringOut", 64'(nullSlot), 64'(ringOut));
      end else if (ringOut !== ringIn) begin
        reportValue("ringOut", 64'(ringIn), 64'(ringOut));  // plain pass-through
      end
    end
  end

  initial begin
    #(budgetCycles * 8);
    $display("watchdog expired, run took longer than the test budget");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    clock = 0;
    reset = 1;
    ringIn = '{payload: 32'd0, kind: slotNull, source: 4'd0};
    readReturn = '0;
    readDest = 4'd0;
    txDesc = '0;
    txAddr = '0;
    txDescEmpty = 1;
    txStop = 0;
    rxHead = '0;
    rxReady = 0;
    rxAddr = '0;
    rxAddrEmpty = 1;
    void'($urandom(32'h38c0));
    repeat (10) @(posedge clock);
    #1 reset = 0;

    e0 = errors;
    quietWatch = 1;
    repeat (60) @(posedge clock);
    quietWatch = 0;
    reportTest("reset and pass-through");

    e0 = errors;
    repeat (4) addDescriptor(1 + $urandom % 1500);
    waitIdle(12000);
    reportTest("transmit");

    e0 = errors;
    repeat (6) addFrame(1 + $urandom % 60, lineAddr'($urandom) | 28'd1);
    waitIdle(5000);
    reportTest("receive");

    e0 = errors;
    addFrame(1 + $urandom % 60, '0);             // zero address drops the frame
    addFrame(1 + $urandom % 60, lineAddr'($urandom) | 28'd1);
    addFrame(1 + $urandom % 60, '0);
    addFrame(1 + $urandom % 60, lineAddr'($urandom) | 28'd1);
    waitIdle(4000);
    reportTest("discard");

    e0 = errors;
    rel0 = releases;
    allowOwn = 1;
    repeat (2) addDescriptor(1 + $urandom % 1500);
    repeat (3) addFrame(1 + $urandom % 60, lineAddr'($urandom) | 28'd1);
    waitIdle(12000);
    allowOwn = 0;
    if (releases == rel0) failNote("no token released by the core");
    reportTest("token discipline");

    e0 = errors;
    repeat (3) addDescriptor(600 + $urandom % 900);
    repeat (40) @(posedge clock);
    #1 txStop = 1;
    repeat (60) @(posedge clock);                // let a latched read go out
    stopWatch = 1;
    repeat (300) @(posedge clock);
    stopWatch = 0;
    #1 txStop = 0;
    waitIdle(15000);
    reportTest("transmit stop");

    $display("tests run: 6, errors: %0d", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* hw/ethDmaTop.sv */
`timescale 1ns/1ps

module ethDmaTop
  import ringPkg::*;
  import dmaPkg::*;
(
  input  logic                        clock,
  input  logic                        reset,
  input  coreId                       coreNumber,
  input  ringSlot                     ringIn,
  output ringSlot                     ringOut,
  input  logic [31:0]                 readReturn,
  input  coreId                       readDest,
  input  txDescriptor                 txDesc,
  input  lineAddr                     txAddr,    // travels with txDesc
  input  logic                        txDescEmpty,
  output logic                        txDescRead,
  output logic [31:0]                 txWord,
  output logic                        txWrite,
  input  logic                        txStop,
  input  dmaPkg::rxWord               rxWord,
  input  logic                        rxReady,
  output logic                        rxRead,
  input  lineAddr                     rxAddr,
  input  logic                        rxAddrEmpty,
  output logic                        rxAddrRead,
  output logic [frameLengthWidth-1:0] frameLength,
  output logic                        frameLengthWrite
);

  logic        readRequest;
  logic        writeRequest;
  logic        acquire;
  ringCmd      cmd;
  logic [31:0] readAddr;
  logic [31:0] writeAddr;
  logic [31:0] stageHead;

  txFetch fetch (
    .clock (clock), .reset (reset), .coreNumber (coreNumber),
    .txDesc (txDesc), .txAddr (txAddr), .txDescEmpty (txDescEmpty),
    .txDescRead (txDescRead), .txWord (txWord), .txWrite (txWrite),
    .txStop (txStop), .readReturn (readReturn), .readDest (readDest),
    .cmd (cmd), .readRequest (readRequest), .readAddr (readAddr)
  );

  rxDrain drain (
    .clock (clock), .reset (reset), .rxWord (rxWord), .rxReady (rxReady),
    .rxRead (rxRead), .rxAddr (rxAddr), .rxAddrEmpty (rxAddrEmpty),
    .rxAddrRead (rxAddrRead), .cmd (cmd), .writeRequest (writeRequest),
    .writeAddr (writeAddr), .stageHead (stageHead),
    .frameLength (frameLength), .frameLengthWrite (frameLengthWrite)
  );

  burstSequencer sequencer (
    .clock (clock), .reset (reset), .readRequest (readRequest),
    .writeRequest (writeRequest), .acquire (acquire), .cmd (cmd)
  );

  ringPort port (
    .clock (clock), .reset (reset), .coreNumber (coreNumber), .ringIn (ringIn),
    .cmd (cmd), .readAddr (readAddr), .writeAddr (writeAddr),
    .stageHead (stageHead), .acquire (acquire), .ringOut (ringOut)
  );

endmodule

/* hw/ringPort.sv */
`timescale 1ns/1ps

module ringPort
  import ringPkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  coreId       coreNumber,
  input  ringSlot     ringIn,
  input  ringCmd      cmd,
  input  logic [31:0] readAddr,
  input  logic [31:0] writeAddr,
  input  logic [31:0] stageHead,
  output logic        acquire,
  output ringSlot     ringOut
);

  logic held;                                    // token kept during a burst
  logic tokenIn;
  logic burstDrive;
  logic sendToken;
  logic nullify;

  assign tokenIn    = (ringIn.kind == slotToken);
  assign acquire    = cmd.wantsToken & tokenIn & ~held;
  assign burstDrive = cmd.sendRead | cmd.sendData | cmd.sendWriteAddr;
  assign sendToken  = held & ~burstDrive;        // first idle cycle after the burst

  // kill slots that came back to us; a passing token stays alive
  assign nullify = (ringIn.source == coreNumber) & ~tokenIn & (ringIn.kind != slotNull);

  always_ff @(posedge clock) begin
    if (reset) begin
      held <= 1'b0;
    end else if (acquire) begin
      held <= 1'b1;
    end else if (sendToken) begin
      held <= 1'b0;
    end
  end

  always_comb begin
    ringOut = ringIn;                            // pass-through by default
    if (burstDrive) begin
      ringOut.source  = coreNumber;
      ringOut.kind    = cmd.sendData ? slotWriteData : slotAddress;
      ringOut.payload = cmd.sendRead      ? readAddr  :
                        cmd.sendWriteAddr ? writeAddr : stageHead;
    end else if (sendToken | nullify) begin
      ringOut.source  = coreNumber;
      ringOut.kind    = sendToken ? slotToken : slotNull;
      ringOut.payload = '0;
    end
  end

endmodule

/* hw/burstSequencer.sv */
`timescale 1ns/1ps

module burstSequencer
  import ringPkg::*;
  import dmaPkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   readRequest,
  input  logic   writeRequest,
  input  logic   acquire,                        // token taken this cycle
  output ringCmd cmd
);

  typedef enum logic [1:0] {
    seqIdle,
    seqWaitToken,
    seqSendData,                                 // rest of the write data
    seqSendWriteAddr                             // closes a write burst
  } seqState;

  seqState state;
  logic readRequested;                           // requests seen when leaving idle
  logic writeRequested;
  logic [$clog2(burstWords):0] dataLeft;         // data slots still to send
  logic takeNow;

  assign takeNow = (state == seqWaitToken) & acquire;

  // first slot goes out in the same cycle the token arrives
  always_comb begin
    cmd               = '0;
    cmd.wantsToken    = (state == seqWaitToken);
    cmd.sendRead      = takeNow & readRequested;
    cmd.sendData      = (takeNow & ~readRequested) | (state == seqSendData);
    cmd.sendWriteAddr = (state == seqSendWriteAddr);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= seqIdle;
      readRequested  <= 1'b0;
      writeRequested <= 1'b0;
      dataLeft       <= '0;
    end else begin
      case (state)
        seqIdle: if (readRequest | writeRequest) begin
          readRequested  <= readRequest;
          writeRequested <= writeRequest;
          state          <= seqWaitToken;
        end
        seqWaitToken: if (acquire) begin
          if (~writeRequested) begin
            state <= seqIdle;                    // read address only
          end else begin
            // word 1 already sent when no read went first
            dataLeft <= readRequested ? ($clog2(burstWords)+1)'(burstWords)
                                      : ($clog2(burstWords)+1)'(burstWords - 1);
            state    <= seqSendData;
          end
        end
        seqSendData: begin
          dataLeft <= dataLeft - 1'b1;
          if (dataLeft == 1) state <= seqSendWriteAddr;
        end
        seqSendWriteAddr: state <= seqIdle;
        default: state <= seqIdle;
      endcase
    end
  end

endmodule

/* hw/rxDrain.sv */
`timescale 1ns/1ps

module rxDrain
  import ringPkg::*;
  import dmaPkg::*;
(
  input  logic                        clock,
  input  logic                        reset,
  input  dmaPkg::rxWord               rxWord,    // queue head
  input  logic                        rxReady,
  output logic                        rxRead,
  input  lineAddr                     rxAddr,
  input  logic                        rxAddrEmpty,
  output logic                        rxAddrRead,
  input  ringCmd                      cmd,
  output logic                        writeRequest,
  output logic [31:0]                 writeAddr,
  output logic [31:0]                 stageHead,
  output logic [frameLengthWidth-1:0] frameLength,
  output logic                        frameLengthWrite
);

  typedef enum logic [2:0] {
    drainIdle,
    drainAddrWait,                               // frame started, need an address
    drainRequest,                                // write bursts to memory
    drainSendLength,                             // report length, pop last word
    drainDiscard,                                // zero address, throw frame away
    drainLastDiscard                             // pop last word, no report
  } drainState;

  drainState state;
  lineAddr wrAddr;                               // next line to write
  logic stagePush;
  logic stagePop;
  logic stageEmpty;
  logic [stagePtrWidth-1:0] stageCount;
  logic headLast;
  logic ringQuiet;

  assign headLast  = rxReady & rxWord.last;
  assign ringQuiet = (cmd == '0);                // sequencer idle, no burst pending

  // load only payload words, and only below the high mark
  assign stagePush = rxReady & ~rxWord.last & (stageCount < stagePtrWidth'(stageHigh));
  // an empty stage is not popped, so a short burst repeats its last word
  assign stagePop  = ~stageEmpty & (cmd.sendData | (state == drainDiscard));

  assign writeRequest = (state == drainRequest) &
                        ((stageCount >= stagePtrWidth'(burstWords)) | (~stageEmpty & headLast));
  assign writeAddr    = {writeTag, wrAddr};

  assign rxRead     = stagePush | (state == drainSendLength) | (state == drainLastDiscard);
  assign rxAddrRead = (state == drainAddrWait) & ~rxAddrEmpty;

  assign frameLength      = rxWord.data[frameLengthWidth-1:0];  // bytes, good, bad
  assign frameLengthWrite = (state == drainSendLength);

  stageFifo stage (
    .clock (clock),
    .reset (reset),
    .din   (rxWord.data),
    .push  (stagePush),
    .pop   (stagePop),
    .head  (stageHead),
    .empty (stageEmpty),
    .count (stageCount)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= drainIdle;
    end else begin
      case (state)
        drainIdle: if (rxReady) state <= drainAddrWait;  // new frame at the head
        drainAddrWait: if (~rxAddrEmpty) begin
          wrAddr <= rxAddr;
          state  <= (rxAddr != '0) ? drainRequest : drainDiscard;
        end
        drainRequest: begin
          if (cmd.sendWriteAddr) wrAddr <= wrAddr + 1'b1;  // line used up
          // wait for the last burst to leave before reporting
          if (stageEmpty & headLast & ringQuiet) state <= drainSendLength;
        end
        drainSendLength: state <= drainIdle;
        drainDiscard: if (stageEmpty & headLast) state <= drainLastDiscard;
        drainLastDiscard: state <= drainIdle;
        default: state <= drainIdle;
      endcase
    end
  end

endmodule

/* hw/txFetch.sv */
`timescale 1ns/1ps

module txFetch
  import ringPkg::*;
  import dmaPkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  coreId       coreNumber,
  input  txDescriptor txDesc,
  input  lineAddr     txAddr,                    // frame address, pops with txDesc
  input  logic        txDescEmpty,
  output logic        txDescRead,
  output logic [31:0] txWord,
  output logic        txWrite,
  input  logic        txStop,
  input  logic [31:0] readReturn,
  input  coreId       readDest,
  input  ringCmd      cmd,
  output logic        readRequest,
  output logic [31:0] readAddr
);

  typedef enum logic [1:0] {
    fetchIdle,
    fetchGet,                                    // pop descriptor, forward it
    fetchRequest,                                // wait for the read slot
    fetchIncAddr                                 // step to the next line
  } fetchState;

  fetchState state;
  lineAddr rdAddr;                               // next line to read
  logic [6:0] blocksLeft;                        // lines still to request
  logic [9:0] wordCount;                         // returned words still wanted
  logic [6:0] blocksNeeded;
  logic [9:0] wordsNeeded;
  logic returnHit;

  // round partial lines and partial words up
  assign blocksNeeded = {1'b0, txDesc.payloadLength[10:5]} + 7'(|txDesc.payloadLength[4:0]);
  assign wordsNeeded  = {1'b0, txDesc.payloadLength[10:2]} + 10'(|txDesc.payloadLength[1:0]);

  assign returnHit   = (readDest == coreNumber) & (wordCount != '0);
  assign txDescRead  = (state == fetchGet);
  assign readRequest = (state == fetchRequest) & ~txStop;  // txStop holds new reads back
  assign readAddr    = {readTag, rdAddr};

  // descriptor goes first, then returned data
  assign txWord  = (state == fetchGet) ? {5'b0, txDesc} : readReturn;
  assign txWrite = (state == fetchGet) | returnHit;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= fetchIdle;
      wordCount <= '0;
    end else begin
      case (state)
        fetchIdle: if (~txDescEmpty & (wordCount == '0)) state <= fetchGet;
        fetchGet: begin
          rdAddr     <= txAddr;
          blocksLeft <= blocksNeeded;
          wordCount  <= wordsNeeded;
          state      <= (blocksNeeded == '0) ? fetchIdle : fetchRequest;
        end
        fetchRequest: if (cmd.sendRead) state <= fetchIncAddr;  // address is on the ring
        fetchIncAddr: begin
          rdAddr     <= rdAddr + 1'b1;
          blocksLeft <= blocksLeft - 1'b1;
          state      <= (blocksLeft == 7'd1) ? fetchIdle : fetchRequest;
        end
        default: state <= fetchIdle;
      endcase
      if (state != fetchGet && returnHit) wordCount <= wordCount - 1'b1;  // one word landed
    end
  end

endmodule

/* hw/stageFifo.sv */
`timescale 1ns/1ps

module stageFifo
  import dmaPkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  logic [31:0]              din,
  input  logic                     push,
  input  logic                     pop,
  output logic [31:0]              head,
  output logic                     empty,
  output logic [stagePtrWidth-1:0] count
);

  logic [31:0] mem [stageDepth];                 // staging storage
  logic [stagePtrWidth-1:0] rdPtr;
  logic [stagePtrWidth-1:0] wrPtr;
  logic [stagePtrWidth-1:0] lastPtr;             // entry popped most recently
  logic doPop;

  assign empty   = (count == '0);
  assign doPop   = pop & ~empty;                 // pop on empty is ignored
  assign lastPtr = rdPtr - 1'b1;

  // fall-through head, repeats the last popped word once drained
  assign head = empty ? mem[lastPtr] : mem[rdPtr];

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wrPtr] <= din;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1;
      if (doPop) rdPtr <= rdPtr + 1'b1;
      if (push & ~doPop) count <= count + 1'b1;
      else if (doPop & ~push) count <= count - 1'b1;
    end
  end

endmodule

/* hw/dmaPkg.sv */
package dmaPkg;

  typedef logic [27:0] lineAddr;                 // 32-byte cache-line address

  localparam int burstWords    = 8;              // words per cache line
  localparam int stageDepth    = 64;             // receive staging FIFO entries
  localparam int stagePtrWidth = $clog2(stageDepth);
  localparam int stageHigh     = 32;             // stop loading at this occupancy

  localparam int frameLengthWidth = 13;          // byte count, good, bad

  // transmit descriptor as it leaves the descriptor queue
  typedef struct packed {
    logic [6:0]  dmBase;                         // header buffer base
    logic [4:0]  headerLength;
    logic [3:0]  sourceCore;
    logic [10:0] payloadLength;                  // bytes
  } txDescriptor;

  // one entry of the receive word queue
  // on the last entry data[12:0] is the frame length report
  typedef struct packed {
    logic        last;                           // end of frame marker
    logic [31:0] data;
  } rxWord;

endpackage

/* hw/ringPkg.sv */
package ringPkg;

  localparam int coreIdWidth = 4;                // cores on the ring

  typedef logic [coreIdWidth-1:0] coreId;

  // slot kinds carried on the ring
  typedef enum logic [3:0] {
    slotNull      = 4'd0,                        // empty slot
    slotToken     = 4'd1,                        // right to send a burst
    slotAddress   = 4'd2,                        // read or write line address
    slotWriteData = 4'd3                         // one word of a write burst
  } slotKind;

  // one slot as it moves from core to core
  typedef struct packed {
    logic [31:0] payload;                        // data word or tagged address
    slotKind     kind;
    coreId       source;                         // core that put it on the ring
  } ringSlot;

  // top nibble of an address slot, line address below it
  localparam logic [3:0] readTag  = 4'b0001;
  localparam logic [3:0] writeTag = 4'b0000;

  // what the core puts on the ring this cycle
  typedef struct packed {
    logic wantsToken;                            // waiting for a token
    logic sendRead;                              // read address slot
    logic sendData;                              // write data slot
    logic sendWriteAddr;                         // write address slot
  } ringCmd;

endpackage
